// File: Bender.yml
package:
  name: alu_core

sources:
  - files:
      - alu_pkg.sv
      - credit_queue.sv
      - alu_decode.sv
      - alu_execute.sv
      - alu_result.sv
      - alu_core.sv
  - target: test
    files:
      - tb_alu_core.sv

// File: alu_core.sv
`default_nettype none

module alu_core (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  input  logic [alu_pkg::insn_w-1:0]    in_insn,
  output logic                          in_credit,
  output logic                          out_valid,
  output logic [alu_pkg::reg_idx_w-1:0] out_rd,
  output logic [alu_pkg::data_w-1:0]    out_value,
  output logic [3:0]                    out_flags,
  output logic                          out_executed,
  input  logic                          out_credit
);

  logic [alu_pkg::reg_idx_w-1:0] rd_addr_a;
  logic [alu_pkg::reg_idx_w-1:0] rd_addr_b;
  logic [alu_pkg::data_w-1:0]    rd_data_a;
  logic [alu_pkg::data_w-1:0]    rd_data_b;
  logic [3:0]                    cur_flags;
  logic                          wb_valid;
  logic [alu_pkg::reg_idx_w-1:0] wb_rd;
  logic                          wb_flags_written;
  logic                          slot_release;
  logic                          issue_valid;
  alu_pkg::issue_t               issue;
  logic                          res_valid;
  alu_pkg::result_t              res;

  alu_decode u_decode (
    .clk              (clk),
    .rst              (rst),
    .in_valid         (in_valid),
    .in_insn          (in_insn),
    .rd_data_a        (rd_data_a),
    .rd_data_b        (rd_data_b),
    .cur_flags        (cur_flags),
    .wb_valid         (wb_valid),
    .wb_rd            (wb_rd),
    .wb_flags_written (wb_flags_written),
    .slot_release     (slot_release),
    .in_credit        (in_credit),
    .rd_addr_a        (rd_addr_a),
    .rd_addr_b        (rd_addr_b),
    .issue_valid      (issue_valid),
    .issue            (issue)
  );

  alu_execute u_execute (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue       (issue),
    .res_valid   (res_valid),
    .res         (res)
  );

  alu_result u_result (
    .clk              (clk),
    .rst              (rst),
    .res_valid        (res_valid),
    .res              (res),
    .rd_addr_a        (rd_addr_a),
    .rd_addr_b        (rd_addr_b),
    .out_credit       (out_credit),
    .rd_data_a        (rd_data_a),
    .rd_data_b        (rd_data_b),
    .cur_flags        (cur_flags),
    .wb_valid         (wb_valid),
    .wb_rd            (wb_rd),
    .wb_flags_written (wb_flags_written),
    .slot_release     (slot_release),
    .out_valid        (out_valid),
    .out_rd           (out_rd),
    .out_value        (out_value),
    .out_flags        (out_flags),
    .out_executed     (out_executed)
  );

endmodule

`default_nettype wire

// File: alu_decode.sv
`default_nettype none

module alu_decode (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              in_valid,
  input  logic [alu_pkg::insn_w-1:0]        in_insn,
  input  logic [alu_pkg::data_w-1:0]        rd_data_a,
  input  logic [alu_pkg::data_w-1:0]        rd_data_b,
  input  logic [3:0]                        cur_flags,
  input  logic                              wb_valid,
  input  logic [alu_pkg::reg_idx_w-1:0]     wb_rd,
  input  logic                              wb_flags_written,
  input  logic                              slot_release,
  output logic                              in_credit,
  output logic [alu_pkg::reg_idx_w-1:0]     rd_addr_a,
  output logic [alu_pkg::reg_idx_w-1:0]     rd_addr_b,
  output logic                              issue_valid,
  output alu_pkg::issue_t                   issue
);

  logic [alu_pkg::insn_w-1:0]     head;
  logic                           q_empty;
  logic [3:0]                     head_raw_op;
  logic                           known_op;
  alu_pkg::opcode_e               head_op;
  alu_pkg::cond_e                 head_cond;
  logic [alu_pkg::reg_idx_w-1:0]  head_rd;
  logic [alu_pkg::reg_idx_w-1:0]  head_ra;
  logic [alu_pkg::reg_idx_w-1:0]  head_rb;
  logic                           head_sets_flags;
  logic [alu_pkg::reg_n-1:0]      busy;       // register scoreboard
  logic                           flag_busy;
  logic [alu_pkg::slot_cnt_w-1:0] reserved;   // output slots held
  logic                           reg_hazard;
  logic                           flag_hazard;
  logic                           slot_free;
  logic                           fire;

  credit_queue #(
    .payload_t (logic [alu_pkg::insn_w-1:0]),
    .depth     (alu_pkg::in_depth)
  ) u_in_q (
    .clk       (clk),
    .rst       (rst),
    .push      (in_valid),
    .push_data (in_insn),
    .pop       (fire),
    .pop_data  (head),
    .empty     (q_empty),
    .full      ()
  );

  assign head_raw_op = head[alu_pkg::opcode_lsb +: 4];
  assign known_op    = (head_raw_op <= 4'(alu_pkg::op_movi));
  assign head_op     = known_op ? alu_pkg::opcode_e'(head_raw_op) : alu_pkg::op_movi;
  // an unknown code turns into a movi that never executes
  assign head_cond   = known_op ? alu_pkg::cond_e'(head[alu_pkg::cond_lsb +: 4]) : alu_pkg::cc_nv;
  assign head_rd     = head[alu_pkg::rd_lsb +: alu_pkg::reg_idx_w];
  assign head_ra     = head[alu_pkg::ra_lsb +: alu_pkg::reg_idx_w];
  assign head_rb     = head[alu_pkg::rb_lsb +: alu_pkg::reg_idx_w];

  assign head_sets_flags = alu_pkg::sets_flags(head_op);

  assign reg_hazard  = busy[head_ra] | busy[head_rb] | busy[head_rd];
  // a second flag writer waits too, so one busy bit is enough
  assign flag_hazard = flag_busy & ((head_cond != alu_pkg::cc_al) | head_sets_flags);
  assign slot_free   = (int'(reserved) < alu_pkg::out_depth);
  assign fire        = !q_empty && !reg_hazard && !flag_hazard && slot_free;

  assign rd_addr_a = head_ra;  // regfile read is combinational
  assign rd_addr_b = head_rb;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy        <= '0;
      flag_busy   <= 1'b0;
      reserved    <= '0;
      issue_valid <= 1'b0;
      in_credit   <= 1'b0;
    end else begin
      if (wb_valid) begin
        busy[wb_rd] <= 1'b0;
        if (wb_flags_written) begin
          flag_busy <= 1'b0;
        end
      end
      if (fire) begin
        busy[head_rd] <= 1'b1;
        if (head_sets_flags) begin
          flag_busy <= 1'b1;
        end
      end
      case ({fire, slot_release})
        2'b10:   reserved <= reserved + 1'b1;
        2'b01:   reserved <= reserved - 1'b1;
        default: ;
      endcase
      issue_valid <= fire;
      in_credit   <= fire;  // one credit back per instruction leaving
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      issue.opcode    <= head_op;
      issue.cond      <= head_cond;
      issue.rd        <= head_rd;
      issue.operand_a <= rd_data_a;
      issue.operand_b <= rd_data_b;
      issue.imm       <= head[alu_pkg::imm_lsb +: alu_pkg::imm_w];
      issue.flags     <= cur_flags;
    end
  end

  // slot_release from result must stay matched with issues here
  assert property (@(posedge clk) disable iff (rst) int'(reserved) <= alu_pkg::out_depth)
    else $error("alu_decode: output reservations above out_depth");

endmodule

`default_nettype wire

// File: alu_execute.sv
`default_nettype none

module alu_execute (
  input  logic             clk,
  input  logic             rst,
  input  logic             issue_valid,
  input  alu_pkg::issue_t  issue,
  output logic             res_valid,
  output alu_pkg::result_t res
);

  logic [alu_pkg::data_w-1:0]    imm_sx;
  logic [alu_pkg::data_w-1:0]    add_b;
  logic                          add_cin;
  logic [alu_pkg::data_w:0]      sum;
  logic                          ovf;
  logic [alu_pkg::data_w-1:0]    logic_res;
  logic [4:0]                    shamt;
  logic [alu_pkg::data_w-1:0]    shift_res;

  logic                          s1_valid;
  alu_pkg::opcode_e              s1_op;
  logic [alu_pkg::reg_idx_w-1:0] s1_rd;
  logic                          s1_cond_ok;
  logic [alu_pkg::data_w:0]      s1_sum;
  logic                          s1_ovf;
  logic [alu_pkg::data_w-1:0]    s1_logic;
  logic [alu_pkg::data_w-1:0]    s1_shift;
  logic [alu_pkg::data_w-1:0]    s1_a;
  logic [alu_pkg::data_w-1:0]    s1_imm;
  logic [3:0]                    s1_flags;

  logic [alu_pkg::data_w-1:0]    value;
  logic [3:0]                    new_flags;
  logic                          s1_adder;

  function automatic logic cond_true(alu_pkg::cond_e cc, logic [3:0] f);
    logic c;
    logic s;
    logic v;
    logic z;
    c = f[alu_pkg::flag_c];
    s = f[alu_pkg::flag_s];
    v = f[alu_pkg::flag_v];
    z = f[alu_pkg::flag_z];
    case (cc)
      alu_pkg::cc_eq: return z;
      alu_pkg::cc_ne: return !z;
      alu_pkg::cc_cs: return c;
      alu_pkg::cc_cc: return !c;
      alu_pkg::cc_mi: return s;
      alu_pkg::cc_pl: return !s;
      alu_pkg::cc_vs: return v;
      alu_pkg::cc_vc: return !v;
      alu_pkg::cc_hi: return c && !z;
      alu_pkg::cc_ls: return !c || z;
      alu_pkg::cc_ge: return s == v;
      alu_pkg::cc_lt: return s != v;
      alu_pkg::cc_gt: return !z && (s == v);
      alu_pkg::cc_le: return z || (s != v);
      alu_pkg::cc_al: return 1'b1;
      default:        return 1'b0;  // nv
    endcase
  endfunction

  assign imm_sx = {{(alu_pkg::data_w - alu_pkg::imm_w){issue.imm[alu_pkg::imm_w-1]}}, issue.imm};

  always_comb begin
    add_b   = issue.operand_b;
    add_cin = 1'b0;
    case (issue.opcode)
      alu_pkg::op_sub: begin
        add_b   = ~issue.operand_b;  // a + ~b + 1, carry set means no borrow
        add_cin = 1'b1;
      end
      alu_pkg::op_addi: add_b = imm_sx;
      default: ;
    endcase
  end

  assign sum = {1'b0, issue.operand_a} + {1'b0, add_b} + {{alu_pkg::data_w{1'b0}}, add_cin};
  assign ovf = (issue.operand_a[alu_pkg::data_w-1] == add_b[alu_pkg::data_w-1]) &&
               (sum[alu_pkg::data_w-1] != issue.operand_a[alu_pkg::data_w-1]);

  always_comb begin
    case (issue.opcode)
      alu_pkg::op_and: logic_res = issue.operand_a & issue.operand_b;
      alu_pkg::op_or:  logic_res = issue.operand_a | issue.operand_b;
      default:         logic_res = issue.operand_a ^ issue.operand_b;
    endcase
  end

  // shl may take its amount from the immediate
  assign shamt = (issue.opcode == alu_pkg::op_shl && issue.imm[11]) ? issue.imm[4:0]
                                                                     : issue.operand_b[4:0];

  always_comb begin
    case (issue.opcode)
      alu_pkg::op_shl: shift_res = issue.operand_a << shamt;
      alu_pkg::op_shr: shift_res = issue.operand_a >> shamt;
      default:         shift_res = $signed(issue.operand_a) >>> shamt;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      s1_valid  <= issue_valid;
      res_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_op      <= issue.opcode;
    s1_rd      <= issue.rd;
    s1_cond_ok <= cond_true(issue.cond, issue.flags);
    s1_sum     <= sum;
    s1_ovf     <= ovf;
    s1_logic   <= logic_res;
    s1_shift   <= shift_res;
    s1_a       <= issue.operand_a;
    s1_imm     <= imm_sx;
    s1_flags   <= issue.flags;
  end

  assign s1_adder = s1_op inside {alu_pkg::op_add, alu_pkg::op_sub, alu_pkg::op_addi};

  always_comb begin
    case (s1_op)
      alu_pkg::op_and, alu_pkg::op_or, alu_pkg::op_xor: value = s1_logic;
      alu_pkg::op_shl, alu_pkg::op_shr, alu_pkg::op_sar: value = s1_shift;
      alu_pkg::op_sxt: begin
        case (s1_imm[1:0])
          2'd0:    value = {{24{s1_a[7]}}, s1_a[7:0]};
          2'd1:    value = {{16{s1_a[15]}}, s1_a[15:0]};
          default: value = {s1_a[7:0], s1_a[15:8], s1_a[23:16], s1_a[31:24]};
        endcase
      end
      alu_pkg::op_movi: value = s1_imm;
      default:          value = s1_sum[alu_pkg::data_w-1:0];  // adder ops
    endcase
  end

  always_comb begin
    new_flags = s1_flags;
    if (alu_pkg::sets_flags(s1_op)) begin
      new_flags[alu_pkg::flag_c] = s1_adder ? s1_sum[alu_pkg::data_w] : 1'b0;
      new_flags[alu_pkg::flag_v] = s1_adder ? s1_ovf : 1'b0;
      new_flags[alu_pkg::flag_s] = value[alu_pkg::data_w-1];
      new_flags[alu_pkg::flag_z] = (value == '0);
    end
  end

  always_ff @(posedge clk) begin
    res.rd           <= s1_rd;
    res.value        <= value;
    res.flags        <= new_flags;
    res.executed     <= s1_cond_ok;
    res.writes_flags <= alu_pkg::sets_flags(s1_op);  // kept even when not executed
  end

endmodule

`default_nettype wire

// File: alu_pkg.sv
`default_nettype none

package alu_pkg;

  localparam int data_w    = 32;
  localparam int reg_n     = 16;
  localparam int reg_idx_w = 4;
  localparam int insn_w    = 32;
  localparam int imm_w     = 12;

  localparam int in_depth    = 4;  // sender credits after reset
  localparam int out_depth   = 4;
  localparam int out_credits = 4;  // receiver's initial grant

  localparam int slot_cnt_w   = $clog2(out_depth + 1);
  localparam int credit_cnt_w = $clog2(out_credits + 1);

  // flag register bits
  localparam int flag_z = 0;
  localparam int flag_v = 1;
  localparam int flag_s = 2;
  localparam int flag_c = 3;

  // lsb of each instruction field
  localparam int opcode_lsb = 28;
  localparam int cond_lsb   = 24;
  localparam int rd_lsb     = 20;
  localparam int ra_lsb     = 16;
  localparam int rb_lsb     = 12;
  localparam int imm_lsb    = 0;

  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_addi = 4'd2,
    op_and  = 4'd3,
    op_or   = 4'd4,
    op_xor  = 4'd5,
    op_shl  = 4'd6,
    op_shr  = 4'd7,
    op_sar  = 4'd8,
    op_sxt  = 4'd9,
    op_movi = 4'd10  // highest legal code
  } opcode_e;

  typedef enum logic [3:0] {
    cc_eq, cc_ne, cc_cs, cc_cc, cc_mi, cc_pl, cc_vs, cc_vc,
    cc_hi, cc_ls, cc_ge, cc_lt, cc_gt, cc_le, cc_al, cc_nv
  } cond_e;

  typedef struct packed {
    opcode_e                opcode;
    cond_e                  cond;
    logic [reg_idx_w-1:0]   rd;
    logic [data_w-1:0]      operand_a;
    logic [data_w-1:0]      operand_b;
    logic [imm_w-1:0]       imm;
    logic [3:0]             flags;  // flag register at issue
  } issue_t;

  typedef struct packed {
    logic [reg_idx_w-1:0]   rd;
    logic [data_w-1:0]      value;
    logic [3:0]             flags;
    logic                   executed;
    logic                   writes_flags;
  } result_t;

  // adder and logic ops own the flag register
  function automatic logic sets_flags(opcode_e op);
    return op inside {op_add, op_sub, op_addi, op_and, op_or, op_xor};
  endfunction

endpackage

`default_nettype wire

// File: alu_result.sv
`default_nettype none

module alu_result (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          res_valid,
  input  alu_pkg::result_t              res,
  input  logic [alu_pkg::reg_idx_w-1:0] rd_addr_a,
  input  logic [alu_pkg::reg_idx_w-1:0] rd_addr_b,
  input  logic                          out_credit,
  output logic [alu_pkg::data_w-1:0]    rd_data_a,
  output logic [alu_pkg::data_w-1:0]    rd_data_b,
  output logic [3:0]                    cur_flags,
  output logic                          wb_valid,
  output logic [alu_pkg::reg_idx_w-1:0] wb_rd,
  output logic                          wb_flags_written,
  output logic                          slot_release,
  output logic                          out_valid,
  output logic [alu_pkg::reg_idx_w-1:0] out_rd,
  output logic [alu_pkg::data_w-1:0]    out_value,
  output logic [3:0]                    out_flags,
  output logic                          out_executed
);

  logic [alu_pkg::data_w-1:0]       regs [alu_pkg::reg_n];
  logic [3:0]                       flags_q;
  logic [alu_pkg::credit_cnt_w-1:0] credits;
  alu_pkg::result_t                 push_entry;
  alu_pkg::result_t                 head;
  logic                             q_empty;
  logic                             fire;

  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];
  assign cur_flags = flags_q;

  // every result frees its scoreboard entries, executed or not
  assign wb_valid         = res_valid;
  assign wb_rd            = res.rd;
  assign wb_flags_written = res.writes_flags;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < alu_pkg::reg_n; i++) begin
        regs[i] <= '0;
      end
      flags_q <= '0;
    end else if (res_valid && res.executed) begin
      regs[res.rd] <= res.value;
      if (res.writes_flags) begin
        flags_q <= res.flags;
      end
    end
  end

  // report the flag register as it stands after this result
  always_comb begin
    push_entry = res;
    if (!(res.executed && res.writes_flags)) begin
      push_entry.flags = flags_q;
    end
  end

  credit_queue #(
    .payload_t (alu_pkg::result_t),
    .depth     (alu_pkg::out_depth)
  ) u_out_q (
    .clk       (clk),
    .rst       (rst),
    .push      (res_valid),
    .push_data (push_entry),
    .pop       (fire),
    .pop_data  (head),
    .empty     (q_empty),
    .full      ()
  );

  assign fire = !q_empty && (credits != '0);

  assign out_valid    = fire;
  assign slot_release = fire;
  assign out_rd       = head.rd;
  assign out_value    = head.value;
  assign out_flags    = head.flags;
  assign out_executed = head.executed;

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= alu_pkg::credit_cnt_w'(alu_pkg::out_credits);
    end else begin
      case ({fire, out_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: ;
      endcase
    end
  end

  // the receiver never grants past its initial window
  assert property (@(posedge clk) disable iff (rst) int'(credits) <= alu_pkg::out_credits)
    else $error("alu_result: output credits above out_credits");

endmodule

`default_nettype wire

// File: credit_queue.sv
`default_nettype none

module credit_queue #(
  parameter type payload_t = logic,
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     full
);

  payload_t                   mem [depth];
  logic [$clog2(depth)-1:0]   rd_ptr;
  logic [$clog2(depth)-1:0]   wr_ptr;
  logic [$clog2(depth+1)-1:0] count;

  function automatic logic [$clog2(depth)-1:0] next_ptr(logic [$clog2(depth)-1:0] p);
    return (int'(p) == depth - 1) ? '0 : p + 1'b1;  // wraps for any depth
  endfunction

  assign pop_data = mem[rd_ptr];
  assign empty    = (count == '0);
  assign full     = (int'(count) == depth);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // both or neither
      endcase
    end
  end

  // credits upstream must keep these from ever firing
  assert property (@(posedge clk) disable iff (rst) full |-> !push)
    else $error("credit_queue: push while full");

  assert property (@(posedge clk) disable iff (rst) empty |-> !pop)
    else $error("credit_queue: pop while empty");

endmodule

`default_nettype wire

// File: filelist.f
alu_pkg.sv
credit_queue.sv
alu_decode.sv
alu_execute.sv
alu_result.sv
alu_core.sv
tb_alu_core.sv

// File: tb_alu_core.sv
`default_nettype none

module tb_alu_core;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int al           = int'(alu_pkg::cc_al);
  localparam int stall_cycles = 80;
  localparam int n_insn       = 300;  // upper bound over all tests
  localparam int wd_cycles    = n_insn * 20 + stall_cycles + 100;

  typedef struct packed {
    logic [alu_pkg::reg_idx_w-1:0] rd;
    logic [alu_pkg::data_w-1:0]    value;
    logic [3:0]                    flags;
    logic                          executed;
  } exp_t;

  logic                          clk        = 1'b0;
  logic                          rst        = 1'b1;
  logic                          in_valid   = 1'b0;
  logic [alu_pkg::insn_w-1:0]    in_insn    = '0;
  logic                          out_credit = 1'b0;
  logic                          in_credit;
  logic                          out_valid;
  logic [alu_pkg::reg_idx_w-1:0] out_rd;
  logic [alu_pkg::data_w-1:0]    out_value;
  logic [3:0]                    out_flags;
  logic                          out_executed;

  integer seed      = 32'hd980c520;
  integer recv_seed = 32'hd980c520 ^ 32'h0000ffff;

  logic [alu_pkg::data_w-1:0] m_regs [alu_pkg::reg_n];  // in-order reference state
  logic [3:0]                 m_flags;
  exp_t                       exp_q [$];
  exp_t                       exp_head;
  int                         exp_count;
  int sent_cnt    = 0;
  int ret_cnt     = 0;
  int recv_cnt    = 0;
  int granted     = alu_pkg::out_credits;
  int owed        = 0;
  logic hold_credit = 1'b0;
  int errors      = 0;
  int test_count  = 0;
  int err_mark    = 0;

  alu_core UUT (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_insn      (in_insn),
    .in_credit    (in_credit),
    .out_valid    (out_valid),
    .out_rd       (out_rd),
    .out_value    (out_value),
    .out_flags    (out_flags),
    .out_executed (out_executed),
    .out_credit   (out_credit)
  );

  always #2 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    errors++;
  endtask

  task automatic report_fault(input string what);
    $display("%s", what);
    errors++;
  endtask

  assert property (@(posedge clk) $fell(rst) |-> !out_valid && !in_credit)
    else report_fault("out_valid or in_credit high right after reset");

  assert property (@(posedge clk) disable iff (rst) out_valid |-> exp_count > 0)
    else report_fault("result came out with no instruction outstanding");

  assert property (@(posedge clk) disable iff (rst)
                   out_valid && exp_count > 0 |-> out_rd == exp_head.rd)
    else report_mismatch("out_rd", $sampled(out_rd), $sampled(exp_head.rd));

  assert property (@(posedge clk) disable iff (rst)
                   out_valid && exp_count > 0 |-> out_value == exp_head.value)
    else report_mismatch("out_value", $sampled(out_value), $sampled(exp_head.value));

  assert property (@(posedge clk) disable iff (rst)
                   out_valid && exp_count > 0 |-> out_flags == exp_head.flags)
    else report_mismatch("out_flags", $sampled(out_flags), $sampled(exp_head.flags));

  assert property (@(posedge clk) disable iff (rst)
                   out_valid && exp_count > 0 |-> out_executed == exp_head.executed)
    else report_mismatch("out_executed", $sampled(out_executed),
                         $sampled(exp_head.executed));

  assert property (@(posedge clk) disable iff (rst) recv_cnt + int'(out_valid) <= granted)
    else report_fault("more results delivered than output credits granted");

  assert property (@(posedge clk) disable iff (rst)
                   sent_cnt - recv_cnt <= alu_pkg::in_depth + alu_pkg::out_depth + 2)
    else report_fault("too many instructions in flight");

  assert property (@(posedge clk) disable iff (rst) in_credit |-> sent_cnt > ret_cnt)
    else report_fault("input credit returned for an instruction never sent");

  function automatic void refresh_head();
    exp_count = exp_q.size();
    if (exp_count > 0) begin
      exp_head = exp_q[0];
    end
  endfunction

  // receiver: pops expected records, returns credits at random
  always @(posedge clk) begin
    if (out_credit) begin
      granted++;
    end
    if (rst) begin
      out_credit <= 1'b0;
    end else begin
      if (out_valid) begin
        owed++;
        recv_cnt++;
        if (exp_q.size() > 0) begin
          void'(exp_q.pop_front());
        end
        refresh_head();
      end
      if (owed > 0 && !hold_credit && ($random(recv_seed) & 1)) begin
        out_credit <= 1'b1;
        owed--;
      end else begin
        out_credit <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && in_credit) begin
      ret_cnt <= ret_cnt + 1;
    end
  end

  function automatic logic cond_holds(input logic [3:0] cc, input logic [3:0] f);
    logic c;
    logic s;
    logic v;
    logic z;
    c = f[alu_pkg::flag_c];
    s = f[alu_pkg::flag_s];
    v = f[alu_pkg::flag_v];
    z = f[alu_pkg::flag_z];
    case (cc)
      4'd0:    return z;
      4'd1:    return !z;
      4'd2:    return c;
      4'd3:    return !c;
      4'd4:    return s;
      4'd5:    return !s;
      4'd6:    return v;
      4'd7:    return !v;
      4'd8:    return c && !z;
      4'd9:    return !c || z;
      4'd10:   return s == v;
      4'd11:   return s != v;
      4'd12:   return !z && s == v;
      4'd13:   return z || s != v;
      4'd14:   return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic model_step(input logic [31:0] insn);
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [11:0] imm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ix;
    logic [31:0] val;
    logic [32:0] wide;
    logic [4:0]  sh;
    logic [3:0]  nf;
    logic        run;
    logic        arith;
    logic        flag_op;
    exp_t        e;
    op      = insn[31:28];
    rd      = insn[23:20];
    imm     = insn[11:0];
    a       = m_regs[insn[19:16]];
    b       = m_regs[insn[15:12]];
    ix      = {{20{imm[11]}}, imm};
    run     = cond_holds(insn[27:24], m_flags);
    arith   = op inside {alu_pkg::op_add, alu_pkg::op_sub, alu_pkg::op_addi};
    flag_op = arith || op inside {alu_pkg::op_and, alu_pkg::op_or, alu_pkg::op_xor};
    nf      = m_flags;
    wide    = '0;
    case (op)
      alu_pkg::op_add:  wide = {1'b0, a} + {1'b0, b};
      alu_pkg::op_addi: wide = {1'b0, a} + {1'b0, ix};
      alu_pkg::op_sub:  wide = {a >= b, a - b};  // carry means no borrow
      default: ;
    endcase
    sh = (op == alu_pkg::op_shl && imm[11]) ? imm[4:0] : b[4:0];
    case (op)
      alu_pkg::op_and:  val = a & b;
      alu_pkg::op_or:   val = a | b;
      alu_pkg::op_xor:  val = a ^ b;
      alu_pkg::op_shl:  val = a << sh;
      alu_pkg::op_shr:  val = a >> sh;
      alu_pkg::op_sar:  val = $unsigned($signed(a) >>> sh);
      alu_pkg::op_sxt: begin
        if (imm[1:0] == 2'd0) begin
          val = {{24{a[7]}}, a[7:0]};
        end else if (imm[1:0] == 2'd1) begin
          val = {{16{a[15]}}, a[15:0]};
        end else begin
          val = {a[7:0], a[15:8], a[23:16], a[31:24]};
        end
      end
      alu_pkg::op_movi: val = ix;
      default:          val = arith ? wide[31:0] : ix;
    endcase
    if (op > 4'd10) begin
      run = 1'b0;  // unknown code, movi that never writes
    end
    if (flag_op) begin
      nf[alu_pkg::flag_c] = arith ? wide[32] : 1'b0;
      if (op == alu_pkg::op_sub) begin
        nf[alu_pkg::flag_v] = (a[31] != b[31]) && (val[31] != a[31]);
      end else if (arith) begin
        nf[alu_pkg::flag_v] = (a[31] == ((op == alu_pkg::op_add) ? b[31] : ix[31]))
                              && (val[31] != a[31]);
      end else begin
        nf[alu_pkg::flag_v] = 1'b0;
      end
      nf[alu_pkg::flag_s] = val[31];
      nf[alu_pkg::flag_z] = (val == '0);
    end
    e.rd       = rd;
    e.value    = val;
    e.executed = run;
    e.flags    = (run && flag_op) ? nf : m_flags;
    if (run) begin
      m_regs[rd] = val;
      if (flag_op) begin
        m_flags = nf;
      end
    end
    exp_q.push_back(e);
    refresh_head();
  endtask

  function automatic logic [31:0] enc(input int op, input int cc, input int rd,
                                      input int ra, input int rb, input int imm);
    return {op[3:0], cc[3:0], rd[3:0], ra[3:0], rb[3:0], imm[11:0]};
  endfunction

  function automatic logic [31:0] rand_insn(input int op_lo, input int op_n,
                                            input int span, input bit any_cond);
    int op;
    int cc;
    int rd;
    int ra;
    int rb;
    int imm;
    op  = op_lo + $unsigned($random(seed)) % op_n;
    cc  = al;
    if (any_cond && ($unsigned($random(seed)) % 3 == 0)) begin
      cc = $unsigned($random(seed)) % 16;
    end
    rd  = $unsigned($random(seed)) % span;
    ra  = $unsigned($random(seed)) % span;
    rb  = $unsigned($random(seed)) % span;
    imm = $random(seed);
    return enc(op, cc, rd, ra, rb, imm);
  endfunction

  // waits for an input credit, then drives one instruction
  task automatic send(input logic [31:0] insn);
    @(posedge clk);
    while (sent_cnt - ret_cnt >= alu_pkg::in_depth) begin
      in_valid <= 1'b0;
      @(posedge clk);
    end
    in_valid <= 1'b1;
    in_insn  <= insn;
    sent_cnt++;
    model_step(insn);
  endtask

  task automatic finish_test(input string name);
    @(posedge clk);
    in_valid <= 1'b0;
    while (exp_count != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    test_count++;
    $display("test %0d %s: %0d errors", test_count, name, errors - err_mark);
    err_mark = errors;
  endtask

  task automatic load_test_regs();
    send(enc(alu_pkg::op_movi, al, 1, 0, 0, 1));
    send(enc(alu_pkg::op_movi, al, 2, 0, 0, 12'hfff));
    send(enc(alu_pkg::op_movi, al, 3, 0, 0, 0));
    send(enc(alu_pkg::op_shr, al, 4, 2, 1, 0));  // 0x7fffffff
  endtask

  initial begin
    logic [31:0] setter [5];
    for (int i = 0; i < alu_pkg::reg_n; i++) begin
      m_regs[i] = '0;
    end
    m_flags = '0;
    refresh_head();
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < alu_pkg::reg_n; i++) begin
      send(enc(alu_pkg::op_add, al, i, i, i, 0));
    end
    finish_test("reset state");

    send(enc(alu_pkg::op_movi, al, 1, 0, 0, 12'h7ff));
    send(enc(alu_pkg::op_movi, al, 2, 0, 0, 12'hfff));
    send(enc(alu_pkg::op_movi, al, 5, 0, 0, 1));
    send(enc(alu_pkg::op_add, al, 3, 2, 2, 0));    // carry
    send(enc(alu_pkg::op_shr, al, 4, 2, 5, 0));
    send(enc(alu_pkg::op_add, al, 6, 4, 5, 0));    // overflow
    send(enc(alu_pkg::op_sub, al, 7, 5, 5, 0));
    send(enc(alu_pkg::op_sub, al, 8, 5, 2, 0));    // borrow
    send(enc(alu_pkg::op_sub, al, 9, 6, 5, 0));
    send(enc(alu_pkg::op_addi, al, 10, 2, 0, 1));
    send(enc(alu_pkg::op_addi, al, 11, 1, 0, 12'h800));
    send(enc(alu_pkg::op_add, al, 12, 1, 1, 0));
    for (int i = 0; i < 8; i++) begin
      send(rand_insn(int'(alu_pkg::op_add), 3, 13, 0));
    end
    finish_test("add sub addi");

    for (int i = 1; i <= 4; i++) begin
      send(enc(alu_pkg::op_movi, al, i, 0, 0, $random(seed)));
    end
    send(enc(alu_pkg::op_shl, al, 1, 1, 0, 12'h80c));
    for (int m = 0; m < 4; m++) begin
      send(enc(alu_pkg::op_sxt, al, 6, 1, 0, m));
    end
    for (int i = 0; i < 24; i++) begin
      send(rand_insn(int'(alu_pkg::op_and), 8, 8, 0));
    end
    send(enc(11, al, 2, 3, 4, 12'h123));
    send(enc(15, al, 5, 6, 7, 12'h8a5));
    finish_test("logic shift ext movi");

    load_test_regs();
    setter[0] = enc(alu_pkg::op_sub, al, 8, 1, 1, 0);
    setter[1] = enc(alu_pkg::op_add, al, 8, 2, 2, 0);
    setter[2] = enc(alu_pkg::op_add, al, 8, 4, 1, 0);
    setter[3] = enc(alu_pkg::op_sub, al, 8, 1, 2, 0);
    setter[4] = enc(alu_pkg::op_and, al, 8, 3, 1, 0);
    for (int s = 0; s < 5; s++) begin
      for (int c = 0; c < 16; c++) begin
        send(setter[s]);
        if (c % 2 == 1) begin
          send(enc(alu_pkg::op_movi, c, 13, 0, 0, c + 16 * s));
        end else begin
          send(enc(alu_pkg::op_addi, c, 12, 12, 0, 1));
        end
      end
    end
    finish_test("condition codes");

    for (int i = 0; i < 40; i++) begin
      send(rand_insn(0, 11, 4, 1));
    end
    finish_test("dependent chain");

    @(posedge clk);
    hold_credit <= 1'b1;
    fork
      begin
        for (int i = 0; i < 24; i++) begin
          send(rand_insn(0, 11, 8, 1));
        end
      end
      begin
        repeat (stall_cycles) @(posedge clk);
        hold_credit <= 1'b0;
      end
    join
    finish_test("credit stall");

    $display("%0d tests, %0d instructions, %0d errors", test_count, sent_cnt, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles with %0d results outstanding",
             wd_cycles, exp_count);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
